// ==== tb.f ====
+incdir+tests
verilog/core_pkg.sv
verilog/hazard_if.sv
verilog/hazard.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/core.sv
tests/tb_clock.sv
tests/core_checker.sv
tests/tb_core.sv

// ==== tests/tb_defs.svh ====
// opcodes of the supported subset
localparam logic [6:0] OPC_REG = 7'b0110011;
localparam logic [6:0] OPC_IMM = 7'b0010011;
localparam logic [6:0] OPC_LOAD = 7'b0000011;
localparam logic [6:0] OPC_STORE = 7'b0100011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;

localparam int NUM_INST = 40;
localparam int RAM_WORDS = 32;

// program styles, one per test
localparam int MODE_ALU = 0;
localparam int MODE_DEP = 1;
localparam int MODE_MEM = 2;
localparam int MODE_BRANCH = 3;
localparam int MODE_X0 = 4;
localparam int MODE_MIX = 5;

// data ram start contents, unique per test and word
function automatic logic [63:0] ram_fill(input int test_num, input int idx);
	logic [31:0] hi;
	logic [31:0] lo;
	hi = 32'hd1a7_0000 + test_num;
	lo = 32'h0000_0800 ^ (idx * 32'h0001_0003);
	return {hi, lo};
endfunction

// ==== tests/core_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_checker #(
	parameter logic [63:0] RESET_PC = 64'd0
) (
	input logic clk,
	input logic run,
	input int test_num,
	input int test_mode,
	output logic [63:0] model_pc,
	input logic [31:0] model_inst,
	input logic retire_valid,
	input logic [63:0] retire_pc,
	input logic retire_wen,
	input logic [4:0] retire_rd,
	input logic [63:0] retire_wd,
	input logic dmem_we,
	input logic [63:0] dmem_addr,
	input logic [63:0] dmem_wdata,
	output logic done,
	output int tests_run,
	output int tests_failed,
	output int check_count,
	output int error_count
);
	`include "tb_defs.svh"

	// longest legal gap is a few stall or flush cycles
	localparam int GAP_LIMIT = 16;

	logic [63:0] regs [32];
	logic [63:0] mram [RAM_WORDS];
	logic [63:0] st_addr_q [$];
	logic [63:0] st_data_q [$];
	int test_errs;
	int retired;
	int stores;
	int gap;

	function automatic string mode_name(input int m);
		case (m)
			MODE_ALU: return "alu";
			MODE_DEP: return "dependent";
			MODE_MEM: return "memory";
			MODE_BRANCH: return "branch";
			MODE_X0: return "x0 writes";
			default: return "random mix";
		endcase
	endfunction

	task automatic record_error();
		error_count++;
		test_errs++;
	endtask

	task automatic check_hex(input string name, input logic [63:0] exp,
			input logic [63:0] act, output logic ok);
		check_count++;
		ok = (act === exp);
		if (!ok) begin
			$display("[FAIL] test %0d pc %h: %s expected %h, got %h",
				test_num, model_pc, name, exp, act);
			record_error();
		end
	endtask

	task automatic clear_model();
		for (int i = 0; i < 32; i++) begin
			regs[i] = 64'd0;
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			mram[i] = ram_fill(test_num, i);
		end
		st_addr_q.delete();
		st_data_q.delete();
		model_pc = RESET_PC;
		done = 1'b0;
		test_errs = 0;
		retired = 0;
		stores = 0;
		gap = 0;
	endtask

	task automatic finish_test();
		if (st_addr_q.size() != 0) begin
			$display("test %0d: %0d dmem writes had no retiring store",
				test_num, st_addr_q.size());
			record_error();
		end
		done = 1'b1;
		tests_run++;
		if (test_errs != 0) begin
			tests_failed++;
		end
		$display("test %0d (%s): %0d retired, %0d stores, %0d errors",
			test_num, mode_name(test_mode), retired, stores, test_errs);
	endtask

	// one architectural step per retirement
	task automatic retire_step();
		logic [31:0] inst;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] res;
		logic [63:0] addr;
		logic [63:0] next_pc;
		logic wen;
		logic is_store;
		logic taken;
		logic ok;

		inst = model_inst;
		opc = inst[6:0];
		rd = inst[11:7];
		f3 = inst[14:12];
		rs1 = inst[19:15];
		rs2 = inst[24:20];
		a = regs[rs1];
		b = regs[rs2];
		wen = 1'b0;
		is_store = 1'b0;
		taken = 1'b0;
		res = 64'd0;
		addr = 64'd0;
		case (opc)
			OPC_REG: begin
				wen = 1'b1;
				case (f3)
					3'b000: res = inst[30] ? a - b : a + b;
					3'b010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					default: res = a & b;
				endcase
			end
			OPC_IMM: begin
				wen = 1'b1;
				res = a + {{52{inst[31]}}, inst[31:20]};
			end
			OPC_LOAD: begin
				wen = 1'b1;
				addr = a + {{52{inst[31]}}, inst[31:20]};
				res = mram[addr[7:3]];
			end
			OPC_STORE: begin
				is_store = 1'b1;
				addr = a + {{52{inst[31]}}, inst[31:25], inst[11:7]};
			end
			OPC_BRANCH: begin
				// funct3 bit 0 selects bne
				taken = f3[0] ? (a != b) : (a == b);
			end
			default: begin
				$display("test %0d: model found unknown instruction %h at pc %h",
					test_num, inst, model_pc);
				record_error();
			end
		endcase
		if (taken) begin
			next_pc = model_pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25],
				inst[11:8], 1'b0};
		end else begin
			next_pc = model_pc + 64'd4;
		end
		retired++;

		check_hex("retire_pc", model_pc, retire_pc, ok);
		if (!ok) begin
			// the streams have diverged, nothing after this is meaningful
			finish_test();
		end else begin
			check_hex("retire_wen", {63'd0, wen}, {63'd0, retire_wen}, ok);
			if (wen) begin
				check_hex("retire_rd", {59'd0, rd}, {59'd0, retire_rd}, ok);
				check_hex("retire_wd", res, retire_wd, ok);
			end
			if (is_store) begin
				stores++;
				if (st_addr_q.size() == 0) begin
					$display("test %0d: store at pc %h never appeared on dmem",
						test_num, model_pc);
					record_error();
				end else begin
					check_hex("dmem_addr", addr, st_addr_q.pop_front(), ok);
					check_hex("dmem_wdata", b, st_data_q.pop_front(), ok);
				end
				mram[addr[7:3]] = b;
			end else if (st_addr_q.size() != 0) begin
				$display("test %0d: unexpected dmem write to %h before pc %h retired",
					test_num, st_addr_q[0], model_pc);
				record_error();
				st_addr_q.delete();
				st_data_q.delete();
			end
			if (wen && rd != 5'd0) begin
				regs[rd] = res;
			end
			// a branch to itself ends the program
			if (taken && next_pc == model_pc) begin
				finish_test();
			end else begin
				model_pc = next_pc;
			end
		end
	endtask

	initial begin
		tests_run = 0;
		tests_failed = 0;
		check_count = 0;
		error_count = 0;
		clear_model();
		forever begin
			@(negedge clk);
			if (!run) begin
				clear_model();
			end else if (!done) begin
				if (retire_valid) begin
					gap = 0;
					retire_step();
				end else begin
					gap++;
					if (gap > GAP_LIMIT) begin
						$display("test %0d: no instruction retired for %0d cycles, expected pc %h",
							test_num, gap, model_pc);
						record_error();
						finish_test();
					end
				end
				// a store shows on dmem one cycle before it retires
				if (dmem_we && !done) begin
					st_addr_q.push_back(dmem_addr);
					st_data_q.push_back(dmem_wdata);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD = 40.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== tests/tb_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_core;
	`include "tb_defs.svh"

	localparam logic [63:0] RESET_PC = 64'd0;
	localparam int NUM_TESTS = 9;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT = NUM_TESTS * (8 * NUM_INST + 20);

	localparam int K_ALU = 0;
	localparam int K_ADDI = 1;
	localparam int K_LOAD = 2;
	localparam int K_STORE = 3;
	localparam int K_BRANCH = 4;

	logic clk;
	logic rst;
	logic [63:0] imem_addr;
	logic [31:0] imem_data;
	logic [63:0] dmem_addr;
	logic [63:0] dmem_wdata;
	logic dmem_we;
	logic [63:0] dmem_rdata;
	logic retire_valid;
	logic [63:0] retire_pc;
	logic retire_wen;
	logic [4:0] retire_rd;
	logic [63:0] retire_wd;

	logic run;
	logic load_ram;
	logic test_done;
	int test_num;
	int test_mode;
	logic [63:0] model_pc;
	logic [31:0] model_inst;
	int tests_run;
	int tests_failed;
	int check_count;
	int error_count;
	int cycles = 0;

	logic [31:0] rom [256];
	logic [63:0] ram [RAM_WORDS];

	tb_clock u_clock (
		.clk
	);

	core #(
		.RESET_PC(RESET_PC)
	) uut (
		.clk,
		.rst,
		.imem_addr,
		.imem_data,
		.dmem_addr,
		.dmem_wdata,
		.dmem_we,
		.dmem_rdata,
		.retire_valid,
		.retire_pc,
		.retire_wen,
		.retire_rd,
		.retire_wd
	);

	core_checker #(
		.RESET_PC(RESET_PC)
	) u_checker (
		.clk,
		.run,
		.test_num,
		.test_mode,
		.model_pc,
		.model_inst,
		.retire_valid,
		.retire_pc,
		.retire_wen,
		.retire_rd,
		.retire_wd,
		.dmem_we,
		.dmem_addr,
		.dmem_wdata,
		.done(test_done),
		.tests_run,
		.tests_failed,
		.check_count,
		.error_count
	);

	// both memories answer within the cycle
	assign imem_data = rom[imem_addr[9:2]];
	assign dmem_rdata = ram[dmem_addr[7:3]];
	assign model_inst = rom[model_pc[9:2]];

	always @(posedge clk) begin
		if (load_ram) begin
			for (int i = 0; i < RAM_WORDS; i++) begin
				ram[i] <= ram_fill(test_num, i);
			end
		end else if (dmem_we) begin
			ram[dmem_addr[7:3]] <= dmem_wdata;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles in test %0d", cycles, test_num);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// op 0..5 is add, sub, and, or, xor, slt
	function automatic logic [31:0] alu_word(input int op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		logic [6:0] f7;
		logic [2:0] f3;
		f7 = 7'd0;
		case (op)
			1: begin
				f7 = 7'h20;
				f3 = 3'b000;
			end
			2: f3 = 3'b111;
			3: f3 = 3'b110;
			4: f3 = 3'b100;
			5: f3 = 3'b010;
			default: f3 = 3'b000;
		endcase
		return {f7, rs2, rs1, f3, rd, OPC_REG};
	endfunction

	function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, OPC_IMM};
	endfunction

	function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [11:0] imm);
		return {imm, 5'd0, 3'b011, rd, OPC_LOAD};
	endfunction

	function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, 5'd0, 3'b011, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] branch_word(input logic bne, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic int pick_kind(input int mode, input logic [3:0] sel);
		case (mode)
			MODE_ALU, MODE_DEP: return (sel < 10) ? K_ALU : K_ADDI;
			MODE_MEM: return (sel < 5) ? K_STORE : (sel < 10) ? K_LOAD :
				(sel < 13) ? K_ADDI : K_ALU;
			MODE_BRANCH: return (sel < 7) ? K_BRANCH : (sel < 12) ? K_ALU : K_ADDI;
			MODE_X0: return (sel < 8) ? K_ALU : (sel < 13) ? K_ADDI : K_BRANCH;
			default: return (sel < 5) ? K_ALU : (sel < 8) ? K_ADDI : (sel < 10) ? K_LOAD :
				(sel < 12) ? K_STORE : K_BRANCH;
		endcase
	endfunction

	// unused words are nops carrying their own index
	task automatic clear_rom();
		for (int i = 0; i < 256; i++) begin
			rom[i] = {12'(i), 5'd0, 3'b000, 5'd0, OPC_IMM};
		end
	endtask

	task automatic build_program(input int mode, input logic [31:0] seed);
		logic [31:0] r;
		logic [31:0] q;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] last_rd;
		logic [4:0] slot;
		logic [11:0] addr_imm;
		int kind;
		int span;
		int k;

		clear_rom();
		r = seed;
		last_rd = 5'd1;
		for (int i = 0; i < NUM_INST - 1; i++) begin
			r = xorshift32(r);
			q = xorshift32(r ^ 32'h5bd1_e995);
			rd = {2'b00, r[2:0]};
			rs1 = {2'b00, r[5:3]};
			rs2 = {2'b00, r[8:6]};
			slot = q[12] ? q[17:13] : {3'b000, q[14:13]};
			addr_imm = {4'd0, slot, 3'b000};
			kind = pick_kind(mode, q[3:0]);
			if (i < 7) begin
				// give x1..x7 signed start values
				rom[i] = addi_word(5'(i + 1), 5'd0, r[20:9]);
			end else begin
				case (mode)
					MODE_DEP: begin
						if (rd == 5'd0) begin
							rd = 5'd7;
						end
						rs1 = last_rd;
						if (q[7]) begin
							rs2 = last_rd;
						end
					end
					MODE_X0: begin
						if (q[4]) begin
							rd = 5'd0;
						end
						if (q[5]) begin
							rs1 = 5'd0;
						end
					end
					MODE_BRANCH: begin
						if (q[6]) begin
							rs2 = rs1;
						end
					end
					default: begin
					end
				endcase
				case (kind)
					K_ALU: rom[i] = alu_word(int'(r[23:21]) % 6, rd, rs1, rs2);
					K_ADDI: rom[i] = addi_word(rd, rs1, r[20:9]);
					K_LOAD: rom[i] = load_word(rd, addr_imm);
					K_STORE: rom[i] = store_word(rs2, addr_imm);
					default: begin
						// forward only, never past the final loop
						span = NUM_INST - 1 - i;
						k = 1 + int'(q[11:9]);
						if (k > span) begin
							k = span;
						end
						rom[i] = branch_word(q[8], rs1, rs2, 13'(4 * k));
					end
				endcase
				if (kind == K_ALU || kind == K_ADDI || kind == K_LOAD) begin
					last_rd = rd;
				end
			end
		end
		rom[NUM_INST - 1] = branch_word(1'b0, 5'd0, 5'd0, 13'd0);
	endtask

	initial begin
		logic [31:0] seed;
		int mode;

		rst = 1'b1;
		run = 1'b0;
		load_ram = 1'b0;
		test_num = 0;
		test_mode = MODE_ALU;
		clear_rom();
		for (int t = 0; t < NUM_TESTS; t++) begin
			mode = (t < MODE_MIX) ? t : MODE_MIX;
			seed = 32'h97a5 ^ (32'(t) * 32'h9e37_79b9);
			if (seed == 32'd0) begin
				seed = 32'h97a5;
			end
			@(posedge clk);
			rst <= 1'b1;
			run <= 1'b0;
			load_ram <= 1'b1;
			test_num <= t;
			test_mode <= mode;
			@(negedge clk);
			build_program(mode, seed);
			@(posedge clk);
			load_ram <= 1'b0;
			repeat (RESET_CYCLES - 1) @(posedge clk);
			rst <= 1'b0;
			run <= 1'b1;
			@(posedge clk);
			while (!test_done) begin
				@(posedge clk);
			end
		end
		$display("%0d tests run, %0d passed, %0d failed, %0d checks, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, check_count, error_count);
		if (error_count == 0 && tests_run == NUM_TESTS) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/core.sv ====
`timescale 1ns/10ps
`default_nettype none

module core #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input logic clk,
	input logic rst,
	output core_pkg::word_t imem_addr,
	input logic [31:0] imem_data,
	output core_pkg::word_t dmem_addr,
	output core_pkg::word_t dmem_wdata,
	output logic dmem_we,
	input core_pkg::word_t dmem_rdata,
	output logic retire_valid,
	output core_pkg::word_t retire_pc,
	output logic retire_wen,
	output core_pkg::reg_addr_t retire_rd,
	output core_pkg::word_t retire_wd
);
	import core_pkg::*;

	word_t pc;
	word_t branch_target;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t rd1;
	word_t rd2;
	dec_data_t dec;
	exe_data_t exe;
	mem_data_t wb;

	hazard_if hif ();

	hazard u_hazard (
		.h(hif.ctl)
	);

	fetch #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk,
		.rst,
		.stall(hif.stall),
		.flush(hif.flush),
		.branch_target,
		.imem_addr,
		.pc
	);

	regfile u_regfile (
		.clk,
		.rst,
		.rs1,
		.rs2,
		.rd1,
		.rd2,
		.wen(wb.reg_write),
		.wa(wb.rd),
		.wd(wb.wd)
	);

	decode u_decode (
		.clk,
		.rst,
		.pc,
		.imem_data,
		.h(hif.src),
		.rs1,
		.rs2,
		.rd1,
		.rd2,
		.stall(hif.stall),
		.flush(hif.flush),
		.dec
	);

	execute u_execute (
		.clk,
		.rst,
		.dec,
		.stall(hif.stall),
		.flush(hif.flush),
		.h(hif.src),
		.branch_target,
		.exe
	);

	memory u_memory (
		.clk,
		.rst,
		.exe,
		.h(hif.src_m),
		.dmem_addr,
		.dmem_wdata,
		.dmem_we,
		.dmem_rdata,
		.wb
	);

	// retire port is the writeback record
	assign retire_valid = wb.valid;
	assign retire_pc = wb.pc;
	assign retire_wen = wb.reg_write;
	assign retire_rd = wb.rd;
	assign retire_wd = wb.wd;

endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

	typedef logic [63:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset bits are scattered over the word
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
	} inst_t;

	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	// addi x0,x0,0
	localparam logic [31:0] NOP_INST = 32'h0000_0013;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic use_imm;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic branch;
		logic branch_ne;
	} ctl_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		ctl_t ctl;
		reg_addr_t rd;
		word_t rs1_val;
		word_t rs2_val;
		word_t imm;
	} dec_data_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		ctl_t ctl;
		reg_addr_t rd;
		word_t alu_out;
		word_t store_data;
	} exe_data_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		logic reg_write;
		reg_addr_t rd;
		word_t wd;
	} mem_data_t;

endpackage

`default_nettype wire

// ==== verilog/decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode (
	input logic clk,
	input logic rst,
	input core_pkg::word_t pc,
	input logic [31:0] imem_data,
	hazard_if.src h,
	output core_pkg::reg_addr_t rs1,
	output core_pkg::reg_addr_t rs2,
	input core_pkg::word_t rd1,
	input core_pkg::word_t rd2,
	input logic stall,
	input logic flush,
	output core_pkg::dec_data_t dec
);
	import core_pkg::*;

	word_t pc_q;
	inst_t inst_q;
	logic valid_q;

	ctl_t ctl;
	word_t imm;
	logic use_rs1;
	logic use_rs2;

	// fetch/decode register
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			inst_q <= NOP_INST;
		end else if (flush) begin
			valid_q <= 1'b0;
			inst_q <= NOP_INST;
		end else if (!stall) begin
			valid_q <= 1'b1;
			pc_q <= pc;
			inst_q <= imem_data;
		end
	end

	always_comb begin
		ctl = '0;
		ctl.alu_op = ALU_ADD;
		imm = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (inst_q.r_fmt.opcode)
			OP_REG: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				ctl.reg_write = 1'b1;
				case (inst_q.r_fmt.funct3)
					3'b000: ctl.alu_op = inst_q.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
					3'b010: ctl.alu_op = ALU_SLT;
					3'b100: ctl.alu_op = ALU_XOR;
					3'b110: ctl.alu_op = ALU_OR;
					3'b111: ctl.alu_op = ALU_AND;
					default: ctl.reg_write = 1'b0;
				endcase
			end
			OP_IMM: begin
				// addi only
				use_rs1 = 1'b1;
				ctl.use_imm = 1'b1;
				ctl.reg_write = (inst_q.i_fmt.funct3 == 3'b000);
				imm = {{52{inst_q.i_fmt.imm[11]}}, inst_q.i_fmt.imm};
			end
			OP_LOAD: begin
				use_rs1 = 1'b1;
				ctl.use_imm = 1'b1;
				ctl.mem_read = (inst_q.i_fmt.funct3 == 3'b011);
				ctl.reg_write = ctl.mem_read;
				imm = {{52{inst_q.i_fmt.imm[11]}}, inst_q.i_fmt.imm};
			end
			OP_STORE: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				ctl.use_imm = 1'b1;
				ctl.mem_write = (inst_q.s_fmt.funct3 == 3'b011);
				imm = {{52{inst_q.s_fmt.imm_hi[6]}}, inst_q.s_fmt.imm_hi, inst_q.s_fmt.imm_lo};
			end
			OP_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				ctl.alu_op = ALU_SUB;
				ctl.branch = (inst_q.b_fmt.funct3[2:1] == 2'b00);
				ctl.branch_ne = inst_q.b_fmt.funct3[0];
				imm = {{51{inst_q.b_fmt.imm12}}, inst_q.b_fmt.imm12, inst_q.b_fmt.imm11,
					inst_q.b_fmt.imm10_5, inst_q.b_fmt.imm4_1, 1'b0};
			end
			default: begin
				ctl = '0;
			end
		endcase
	end

	assign rs1 = inst_q.r_fmt.rs1;
	assign rs2 = inst_q.r_fmt.rs2;

	assign h.d_rs1 = inst_q.r_fmt.rs1;
	assign h.d_rs2 = inst_q.r_fmt.rs2;
	assign h.d_use_rs1 = valid_q && use_rs1;
	assign h.d_use_rs2 = valid_q && use_rs2;

	always_comb begin
		dec.valid = valid_q;
		dec.pc = pc_q;
		dec.ctl = ctl;
		// rd field holds immediate bits for stores and branches
		dec.rd = ctl.reg_write ? inst_q.r_fmt.rd : 5'd0;
		dec.rs1_val = rd1;
		dec.rs2_val = rd2;
		dec.imm = imm;
	end

endmodule

`default_nettype wire

// ==== verilog/execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute (
	input logic clk,
	input logic rst,
	input core_pkg::dec_data_t dec,
	input logic stall,
	input logic flush,
	hazard_if.src h,
	output core_pkg::word_t branch_target,
	output core_pkg::exe_data_t exe
);
	import core_pkg::*;

	dec_data_t dq;

	word_t opb;
	word_t alu;
	logic eq;

	// decode/execute register, bubble on stall or flush
	always_ff @(posedge clk) begin
		if (rst || stall || flush) begin
			dq <= '0;
		end else begin
			dq <= dec;
		end
	end

	assign opb = dq.ctl.use_imm ? dq.imm : dq.rs2_val;

	always_comb begin
		case (dq.ctl.alu_op)
			ALU_SUB: alu = dq.rs1_val - opb;
			ALU_AND: alu = dq.rs1_val & opb;
			ALU_OR: alu = dq.rs1_val | opb;
			ALU_XOR: alu = dq.rs1_val ^ opb;
			ALU_SLT: alu = {63'd0, $signed(dq.rs1_val) < $signed(opb)};
			default: alu = dq.rs1_val + opb;
		endcase
	end

	assign eq = (dq.rs1_val == dq.rs2_val);

	// bne flips the compare
	assign h.branch_taken = dq.valid && dq.ctl.branch && (eq ^ dq.ctl.branch_ne);
	assign branch_target = dq.pc + dq.imm;

	assign h.e_rd = dq.rd;
	assign h.e_wr = dq.valid && dq.ctl.reg_write;

	always_comb begin
		exe.valid = dq.valid;
		exe.pc = dq.pc;
		exe.ctl = dq.ctl;
		exe.rd = dq.rd;
		exe.alu_out = alu;
		exe.store_data = dq.rs2_val;
	end

endmodule

`default_nettype wire

// ==== verilog/fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic flush,
	input core_pkg::word_t branch_target,
	output core_pkg::word_t imem_addr,
	output core_pkg::word_t pc
);

	// flush wins over stall
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (flush) begin
			pc <= branch_target;
		end else if (!stall) begin
			pc <= pc + 64'd4;
		end
	end

	assign imem_addr = pc;

endmodule

`default_nettype wire

// ==== verilog/hazard.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard (
	hazard_if.ctl h
);

	logic rs1_dep;
	logic rs2_dep;

	// x0 never causes a dependence
	always_comb begin
		rs1_dep = h.d_use_rs1 && (h.d_rs1 != 5'd0) &&
			((h.e_wr && (h.d_rs1 == h.e_rd)) || (h.m_wr && (h.d_rs1 == h.m_rd)));
		rs2_dep = h.d_use_rs2 && (h.d_rs2 != 5'd0) &&
			((h.e_wr && (h.d_rs2 == h.e_rd)) || (h.m_wr && (h.d_rs2 == h.m_rd)));
	end

	// writeback distance is covered by regfile write-through
	assign h.flush = h.branch_taken;

	// a taken branch kills the stalled instruction anyway
	assign h.stall = (rs1_dep || rs2_dep) && !h.branch_taken;

endmodule

`default_nettype wire

// ==== verilog/hazard_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface hazard_if;
	import core_pkg::*;

	// sources seen by the control unit
	reg_addr_t d_rs1;
	reg_addr_t d_rs2;
	logic d_use_rs1;
	logic d_use_rs2;
	reg_addr_t e_rd;
	logic e_wr;
	logic branch_taken;
	reg_addr_t m_rd;
	logic m_wr;

	// controls back to the pipeline
	logic stall;
	logic flush;

	modport src (
		output d_rs1, d_rs2, d_use_rs1, d_use_rs2,
		output e_rd, e_wr, branch_taken
	);

	modport src_m (
		output m_rd, m_wr
	);

	modport ctl (
		input d_rs1, d_rs2, d_use_rs1, d_use_rs2,
		input e_rd, e_wr, branch_taken, m_rd, m_wr,
		output stall, flush
	);

endinterface

`default_nettype wire

// ==== verilog/memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory (
	input logic clk,
	input logic rst,
	input core_pkg::exe_data_t exe,
	hazard_if.src_m h,
	output core_pkg::word_t dmem_addr,
	output core_pkg::word_t dmem_wdata,
	output logic dmem_we,
	input core_pkg::word_t dmem_rdata,
	output core_pkg::mem_data_t wb
);
	import core_pkg::*;

	exe_data_t mq;

	// execute/memory register
	always_ff @(posedge clk) begin
		if (rst) begin
			mq <= '0;
		end else begin
			mq <= exe;
		end
	end

	assign dmem_addr = mq.alu_out;
	assign dmem_wdata = mq.store_data;
	assign dmem_we = mq.valid && mq.ctl.mem_write;

	assign h.m_rd = mq.rd;
	assign h.m_wr = mq.valid && mq.ctl.reg_write;

	// memory/writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			wb.valid <= 1'b0;
			wb.reg_write <= 1'b0;
		end else begin
			wb.valid <= mq.valid;
			wb.reg_write <= mq.valid && mq.ctl.reg_write;
		end
		wb.pc <= mq.pc;
		wb.rd <= mq.rd;
		wb.wd <= mq.ctl.mem_read ? dmem_rdata : mq.alu_out;
	end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input logic clk,
	input logic rst,
	input core_pkg::reg_addr_t rs1,
	input core_pkg::reg_addr_t rs2,
	output core_pkg::word_t rd1,
	output core_pkg::word_t rd2,
	input logic wen,
	input core_pkg::reg_addr_t wa,
	input core_pkg::word_t wd
);
	import core_pkg::*;

	word_t regs [32];

	logic wr_live;

	assign wr_live = wen && (wa != 5'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wa] <= wd;
		end
	end

	// same-cycle write is visible to decode
	assign rd1 = (wr_live && (wa == rs1)) ? wd : regs[rs1];
	assign rd2 = (wr_live && (wa == rs2)) ? wd : regs[rs2];

endmodule

`default_nettype wire
